// ==== design/onset_pkg.sv ====
package onset_pkg;

    // word sizes
    parameter int SAMPLE_W  = 16;
    parameter int ADDR_W    = 20;
    parameter int FLUX_W    = SAMPLE_W + 3;   // sum of 8 positive differences

    // frame and window geometry
    parameter int N_BINS    = 8;
    parameter int BIN_IDX_W = 3;
    parameter int WIN_SIZE  = 16;
    parameter int WIN_IDX_W = 4;

    typedef logic signed [SAMPLE_W-1:0] sample_t;  // real or imaginary word
    typedef logic [SAMPLE_W-1:0]        mag_t;
    typedef logic [ADDR_W-1:0]          addr_t;
    typedef logic [FLUX_W-1:0]          flux_t;

    // controller states with one frame per pass from IDLE back to IDLE
    typedef enum logic [2:0] {
        IDLE,
        LOAD_RE,   // real word on the read port
        LOAD_IM,   // imaginary word and bin go to the accumulator
        FLUX,
        DECIDE,
        WRITE,
        ACK
    } ctrl_state_t;

endpackage

// ==== design/bin_magnitude.sv ====
`timescale 1ns/1ps

module bin_magnitude (
    input  onset_pkg::sample_t i_re,
    input  onset_pkg::sample_t i_im,
    output onset_pkg::mag_t    o_mag
);
    import onset_pkg::*;

    logic [2*SAMPLE_W-1:0] re_sq;
    logic [2*SAMPLE_W:0]   pwr;    // up to 2^31 with one spare bit
    logic [2*SAMPLE_W-1:0] im_sq;
    mag_t                  root;
    mag_t                  trial;

    assign re_sq = i_re * i_re;
    assign im_sq = i_im * i_im;
    assign pwr   = re_sq + im_sq;

    // restoring square root with one result bit per step from the MSB
    always_comb begin
        root  = '0;
        trial = '0;
        for (int k = SAMPLE_W - 1; k >= 0; k--) begin
            trial = root | (mag_t'(1) << k);
            if (trial * trial <= pwr) root = trial;   // 33-bit compare
        end
    end

    assign o_mag = root;

endmodule

// ==== design/spectrum_accumulator.sv ====
`timescale 1ns/1ps

module spectrum_accumulator #(
    parameter int N_ACC = 512
) (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_en,
    input  logic [onset_pkg::BIN_IDX_W-1:0]    i_bin,
    input  onset_pkg::sample_t                 i_re,
    input  onset_pkg::sample_t                 i_im,
    input  logic                               i_last_frame,
    input  logic [onset_pkg::BIN_IDX_W-1:0]    i_rd_bin,
    output onset_pkg::mag_t                    o_spectrum
);
    import onset_pkg::*;

    localparam int ACC_SH = $clog2(N_ACC);
    localparam int ACC_W  = SAMPLE_W + ACC_SH;

    mag_t             mag;
    logic [ACC_W-1:0] acc [N_BINS];
    logic [ACC_W-1:0] acc_sum;
    mag_t             spectrum [N_BINS];

    bin_magnitude u_bin_magnitude (
        .i_re  (i_re),
        .i_im  (i_im),
        .o_mag (mag)
    );

    assign acc_sum = acc[i_bin] + mag;

    // running sums cleared as each bin of the block closes
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int b = 0; b < N_BINS; b++) begin
                acc[b] <= '0;
            end
        end else if (i_en) begin
            acc[i_bin] <= i_last_frame ? '0 : acc_sum;
        end
    end

    // the top SAMPLE_W bits of the sum divide it by N_ACC
    always_ff @(posedge i_clk) begin
        if (i_en && i_last_frame) begin
            spectrum[i_bin] <= acc_sum[ACC_W-1 -: SAMPLE_W];
        end
    end

    assign o_spectrum = spectrum[i_rd_bin];

endmodule

// ==== design/flux_unit.sv ====
`timescale 1ns/1ps

module flux_unit (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_en,
    input  logic [onset_pkg::BIN_IDX_W-1:0] i_bin,
    input  onset_pkg::mag_t                 i_spectrum,
    output onset_pkg::flux_t                o_flux,
    output logic                            o_valid
);
    import onset_pkg::*;

    mag_t  prev [N_BINS];   // spectrum of the previous block
    mag_t  rise;
    flux_t flux_sum;

    // only increases in energy count toward the flux
    assign rise = (i_spectrum > prev[i_bin]) ? i_spectrum - prev[i_bin] : '0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int b = 0; b < N_BINS; b++) begin
                prev[b] <= '0;
            end
            flux_sum <= '0;
            o_valid  <= 1'b0;
        end else begin
            o_valid <= i_en && (i_bin == BIN_IDX_W'(N_BINS - 1));
            if (i_en) begin
                prev[i_bin] <= i_spectrum;
                if (i_bin == '0) begin
                    flux_sum <= flux_t'(rise);   // first bin restarts the sum
                end else begin
                    flux_sum <= flux_sum + rise;
                end
            end
        end
    end

    assign o_flux = flux_sum;

endmodule

// ==== design/beat_window.sv ====
`timescale 1ns/1ps

module beat_window (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_push,
    input  onset_pkg::flux_t i_flux,
    output logic             o_beat,
    output logic             o_valid
);
    import onset_pkg::*;

    localparam int SUM_W = FLUX_W + WIN_IDX_W;

    flux_t                win [WIN_SIZE];
    logic [WIN_IDX_W-1:0] wr_ptr;
    logic [WIN_IDX_W-1:0] mid_ptr;
    logic [SUM_W-1:0]     win_sum;
    flux_t                avg;
    flux_t                judged;
    logic                 beat_nxt;

    // sum of the window as it stands once the new value is stored
    always_comb begin
        win_sum = '0;
        for (int i = 0; i < WIN_SIZE; i++) begin
            win_sum = win_sum + ((wr_ptr == WIN_IDX_W'(i)) ? i_flux : win[i]);
        end
    end

    assign avg     = win_sum[SUM_W-1 -: FLUX_W];
    assign mid_ptr = {~wr_ptr[WIN_IDX_W-1], wr_ptr[WIN_IDX_W-2:0]};  // half a window back
    assign judged  = win[mid_ptr];
    assign beat_nxt = {1'b0, judged} >= {avg, 1'b0};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < WIN_SIZE; i++) begin
                win[i] <= '0;
            end
            wr_ptr  <= '0;
            o_beat  <= 1'b0;
            o_valid <= 1'b0;
        end else if (i_push) begin
            win[wr_ptr] <= i_flux;
            wr_ptr      <= wr_ptr + 1'b1;
            o_beat      <= beat_nxt;
            if (wr_ptr == WIN_IDX_W'(WIN_SIZE - 1)) o_valid <= 1'b1;   // sticky from 16th push
        end
    end

endmodule

// ==== design/onset_ctrl.sv ====
`timescale 1ns/1ps

module onset_ctrl #(
    parameter int               N_ACC       = 512,
    parameter onset_pkg::addr_t RESULT_BASE = 20'h80000
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_req,
    input  onset_pkg::addr_t                i_num_frames,
    input  onset_pkg::sample_t              i_sram_rdata,
    input  logic                            i_flux_valid,
    input  logic                            i_beat,
    input  logic                            i_beat_valid,
    output logic                            o_ack,
    output logic                            o_done,
    output onset_pkg::addr_t                o_sram_addr,
    output onset_pkg::sample_t              o_sram_wdata,
    output logic                            o_sram_we_n,
    output logic                            o_acc_en,
    output logic [onset_pkg::BIN_IDX_W-1:0] o_acc_bin,
    output onset_pkg::sample_t              o_acc_re,
    output onset_pkg::sample_t              o_acc_im,
    output logic                            o_acc_last_frame,
    output logic                            o_flux_en,
    output logic [onset_pkg::BIN_IDX_W-1:0] o_flux_bin,
    output logic                            o_win_push
);
    import onset_pkg::*;

    localparam int ACC_SH = $clog2(N_ACC);

    ctrl_state_t          state;
    ctrl_state_t          state_nxt;
    addr_t                rd_addr;
    addr_t                block_cnt;     // index of the block in progress
    addr_t                frames_done;
    addr_t                result_addr;
    logic [ACC_SH-1:0]    frame_in_blk;
    logic [BIN_IDX_W-1:0] bin_cnt;
    sample_t              re_q;
    logic                 last_bin;
    logic                 last_frame;

    assign last_bin   = (bin_cnt == BIN_IDX_W'(N_BINS - 1));
    assign last_frame = &frame_in_blk;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (i_req && !o_done) state_nxt = LOAD_RE;
            end
            LOAD_RE: state_nxt = LOAD_IM;
            LOAD_IM: begin
                if (last_bin) begin
                    state_nxt = last_frame ? FLUX : ACK;
                end else begin
                    state_nxt = LOAD_RE;
                end
            end
            FLUX: begin
                if (last_bin) state_nxt = DECIDE;
            end
            DECIDE: begin
                // window holds 16 entries once this block is pushed
                if (i_flux_valid) begin
                    state_nxt = (block_cnt >= addr_t'(WIN_SIZE - 1)) ? WRITE : ACK;
                end
            end
            WRITE: state_nxt = ACK;
            ACK: begin
                if (!i_req) state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= IDLE;
            rd_addr      <= '0;
            bin_cnt      <= '0;
            frame_in_blk <= '0;
            block_cnt    <= '0;
            frames_done  <= '0;
        end else begin
            state <= state_nxt;
            if (state == LOAD_RE || state == LOAD_IM) rd_addr <= rd_addr + 1'b1;
            if (state == LOAD_IM || state == FLUX) bin_cnt <= bin_cnt + 1'b1;  // wraps at 8
            if (state == ACK && !i_req) begin
                frames_done  <= frames_done + 1'b1;
                frame_in_blk <= frame_in_blk + 1'b1;
                if (last_frame) block_cnt <= block_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == LOAD_RE) re_q <= i_sram_rdata;
    end

    // the judged block lies half a window behind the current one
    assign result_addr = RESULT_BASE + block_cnt - addr_t'(WIN_SIZE / 2);

    assign o_ack        = (state == ACK);
    assign o_done       = (frames_done >= i_num_frames);
    assign o_sram_addr  = (state == WRITE) ? result_addr : rd_addr;
    assign o_sram_wdata = {{(SAMPLE_W - 1){1'b0}}, i_beat};
    assign o_sram_we_n  = !(state == WRITE && i_beat_valid);

    assign o_acc_en         = (state == LOAD_IM);
    assign o_acc_bin        = bin_cnt;
    assign o_acc_re         = re_q;
    assign o_acc_im         = i_sram_rdata;
    assign o_acc_last_frame = last_frame;
    assign o_flux_en        = (state == FLUX);
    assign o_flux_bin       = bin_cnt;
    assign o_win_push       = (state == DECIDE) && i_flux_valid;

endmodule

// ==== design/onset_detector.sv ====
`timescale 1ns/1ps

module onset_detector #(
    parameter int               N_ACC       = 512,
    parameter onset_pkg::addr_t RESULT_BASE = 20'h80000
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_req,
    input  onset_pkg::addr_t   i_num_frames,
    input  onset_pkg::sample_t i_sram_rdata,
    output logic               o_ack,
    output logic               o_done,
    output onset_pkg::addr_t   o_sram_addr,
    output onset_pkg::sample_t o_sram_wdata,
    output logic               o_sram_we_n
);
    import onset_pkg::*;

    logic                 acc_en;
    logic [BIN_IDX_W-1:0] acc_bin;
    sample_t              acc_re;
    sample_t              acc_im;
    logic                 acc_last_frame;
    logic                 flux_en;
    logic [BIN_IDX_W-1:0] flux_bin;
    mag_t                 spectrum;
    flux_t                flux;
    logic                 flux_valid;
    logic                 win_push;
    logic                 beat;
    logic                 beat_valid;

    onset_ctrl #(
        .N_ACC       (N_ACC),
        .RESULT_BASE (RESULT_BASE)
    ) u_onset_ctrl (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_req            (i_req),
        .i_num_frames     (i_num_frames),
        .i_sram_rdata     (i_sram_rdata),
        .i_flux_valid     (flux_valid),
        .i_beat           (beat),
        .i_beat_valid     (beat_valid),
        .o_ack            (o_ack),
        .o_done           (o_done),
        .o_sram_addr      (o_sram_addr),
        .o_sram_wdata     (o_sram_wdata),
        .o_sram_we_n      (o_sram_we_n),
        .o_acc_en         (acc_en),
        .o_acc_bin        (acc_bin),
        .o_acc_re         (acc_re),
        .o_acc_im         (acc_im),
        .o_acc_last_frame (acc_last_frame),
        .o_flux_en        (flux_en),
        .o_flux_bin       (flux_bin),
        .o_win_push       (win_push)
    );

    spectrum_accumulator #(
        .N_ACC (N_ACC)
    ) u_spectrum_accumulator (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_en         (acc_en),
        .i_bin        (acc_bin),
        .i_re         (acc_re),
        .i_im         (acc_im),
        .i_last_frame (acc_last_frame),
        .i_rd_bin     (flux_bin),
        .o_spectrum   (spectrum)
    );

    flux_unit u_flux_unit (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_en       (flux_en),
        .i_bin      (flux_bin),
        .i_spectrum (spectrum),
        .o_flux     (flux),
        .o_valid    (flux_valid)
    );

    beat_window u_beat_window (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (win_push),
        .i_flux  (flux),
        .o_beat  (beat),
        .o_valid (beat_valid)
    );

endmodule

// ==== verification/onset_model.svh ====
// stimulus size and the result region of this testbench
localparam int    N_ACC       = 4;
localparam int    N_BLOCKS    = 20;
localparam int    N_FRAMES    = N_ACC * N_BLOCKS;
localparam int    FRAME_WORDS = N_BINS * 2;    // re then im for each bin
localparam int    SPEC_WORDS  = N_FRAMES * FRAME_WORDS;
localparam addr_t RESULT_BASE = 20'h80000;

sample_t spec_mem [SPEC_WORDS];   // spectra stored frame after frame from address 0
longint  blk_flux [N_BLOCKS];
logic    exp_beat [N_BLOCKS];     // indexed by the judged block
longint  blk_sum [N_BINS];
longint  prev_spec [N_BINS];

// float estimate of the root corrected to the floor
function automatic longint magnitude_of(input sample_t re, input sample_t im);
    longint re_l;
    longint im_l;
    longint pwr;
    longint r;
    re_l = re;
    im_l = im;
    pwr  = re_l * re_l + im_l * im_l;
    r    = $rtoi($sqrt(pwr));
    while (r * r > pwr)
        r--;
    while ((r + 1) * (r + 1) <= pwr)
        r++;
    return r;
endfunction

task automatic compute_reference();
    longint spec;
    longint win_sum;
    int     a;
    for (int b = 0; b < N_BINS; b++)
        prev_spec[b] = 0;
    for (int k = 0; k < N_BLOCKS; k++) begin
        for (int b = 0; b < N_BINS; b++)
            blk_sum[b] = 0;
        for (int f = 0; f < N_ACC; f++) begin
            for (int b = 0; b < N_BINS; b++) begin
                a = (k * N_ACC + f) * FRAME_WORDS + 2 * b;
                blk_sum[b] += magnitude_of(spec_mem[a], spec_mem[a + 1]);
            end
        end
        blk_flux[k] = 0;
        for (int b = 0; b < N_BINS; b++) begin
            spec = blk_sum[b] / N_ACC;
            if (spec > prev_spec[b])
                blk_flux[k] += spec - prev_spec[b];   // rising energy only
            prev_spec[b] = spec;
        end
        exp_beat[k] = 1'bx;
    end
    // once 16 fluxes exist, judge the one half a window back
    for (int p = WIN_SIZE - 1; p < N_BLOCKS; p++) begin
        win_sum = 0;
        for (int q = p - WIN_SIZE + 1; q <= p; q++)
            win_sum += blk_flux[q];
        exp_beat[p - WIN_SIZE / 2] = (blk_flux[p - WIN_SIZE / 2] >= 2 * (win_sum / WIN_SIZE));
    end
endtask

// ==== verification/tb_onset_detector.sv ====
`timescale 1ns/1ps

module tb_onset_detector;
    import onset_pkg::*;

    localparam int TIMEOUT   = 200;   // cycles per wait
    localparam int BURST_BLK = 9;

    logic    i_clk;
    logic    i_rst_n;
    logic    i_req;
    addr_t   i_num_frames;
    sample_t i_sram_rdata;
    logic    o_ack;
    logic    o_done;
    addr_t   o_sram_addr;
    sample_t o_sram_wdata;
    logic    o_sram_we_n;

    integer seed;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     err_mark;
    int     n_writes;
    int     frame_idx;
    int     ack_count;
    int     judged;
    logic   ack_prev;
    logic   timed_out;
    addr_t  addr_mark;

    `include "onset_model.svh"

    logic   res_bit [N_BLOCKS];

    onset_detector #(
        .N_ACC       (N_ACC),
        .RESULT_BASE (RESULT_BASE)
    ) i_onset_detector (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req        (i_req),
        .i_num_frames (i_num_frames),
        .i_sram_rdata (i_sram_rdata),
        .o_ack        (o_ack),
        .o_done       (o_done),
        .o_sram_addr  (o_sram_addr),
        .o_sram_wdata (o_sram_wdata),
        .o_sram_we_n  (o_sram_we_n)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // async SRAM read where data outside the spectrum area follows the address
    assign i_sram_rdata = (o_sram_addr < SPEC_WORDS) ? spec_mem[o_sram_addr]
                                                     : sample_t'(o_sram_addr ^ (o_sram_addr >> 4));

    task automatic check_word(input sample_t got, input sample_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // count ack edges and check result writes while the bus is stable
    always @(negedge i_clk) begin
        if (o_ack && !ack_prev)
            ack_count++;
        ack_prev = o_ack;
        if (i_rst_n && !o_sram_we_n) begin
            if (n_writes > N_BLOCKS - WIN_SIZE) begin
                errors++;
                $display("ERROR at %0t: unexpected result write to %h", $time, o_sram_addr);
            end else begin
                judged = WIN_SIZE / 2 - 1 + n_writes;
                check_addr(o_sram_addr, RESULT_BASE + addr_t'(judged), "result address");
                check_word(o_sram_wdata, sample_t'({15'b0, exp_beat[judged]}), "result word");
                check_bit(frame_idx == (WIN_SIZE + n_writes) * N_ACC - 1, 1'b1, "write frame");
            end
            if (o_sram_addr - RESULT_BASE < N_BLOCKS)
                res_bit[o_sram_addr - RESULT_BASE] = o_sram_wdata[0];
            n_writes++;
        end
    end

    task automatic apply_reset();
        @(posedge i_clk);
        i_rst_n <= 1'b0;
        i_req   <= 1'b0;
        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        n_writes  = 0;
        frame_idx = 0;
        ack_count = 0;
        for (int j = 0; j < N_BLOCKS; j++)
            res_bit[j] = 1'bx;
    endtask

    task automatic fill_random();
        for (int a = 0; a < SPEC_WORDS; a++) begin
            if (($random(seed) & 7) == 0)
                spec_mem[a] = 16'sh8000;   // most negative word
            else
                spec_mem[a] = sample_t'($random(seed));
        end
    endtask

    // flat magnitude 500 with full scale in one block
    task automatic fill_burst(input int blk);
        for (int a = 0; a < SPEC_WORDS; a++) begin
            if (a / (FRAME_WORDS * N_ACC) == blk)
                spec_mem[a] = 16'sh8000;
            else
                spec_mem[a] = (a % 2 == 0) ? 16'sd300 : 16'sd400;
        end
    endtask

    task automatic wait_ack(input logic level);
        int t;
        t = 0;
        @(negedge i_clk);
        while (o_ack !== level && t < TIMEOUT) begin
            @(negedge i_clk);
            t++;
        end
        if (o_ack !== level) begin
            $display("timeout: o_ack did not go to %b within %0d cycles", level, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_frame(input int hold);
        wait_ack(1'b0);
        if (!timed_out) begin
            @(posedge i_clk);
            i_req <= 1'b1;
            wait_ack(1'b1);
        end
        if (!timed_out) begin
            repeat (hold) begin
                @(negedge i_clk);
                check_bit(o_ack, 1'b1, "ack while req held");
            end
            @(posedge i_clk);
            i_req <= 1'b0;
            wait_ack(1'b0);
        end
        frame_idx++;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors != err_mark || timed_out) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: passed", name);
        end
        err_mark = errors;
    endtask

    initial begin
        seed         = 32'hd05b_f736;
        i_rst_n      = 1'b0;
        i_req        = 1'b0;
        i_num_frames = addr_t'(N_FRAMES);
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_mark     = 0;
        ack_prev     = 1'b0;
        timed_out    = 1'b0;
        fill_random();
        compute_reference();
        apply_reset();

        check_bit(o_ack, 1'b0, "o_ack after reset");
        check_bit(o_sram_we_n, 1'b1, "o_sram_we_n after reset");
        check_bit(o_done, 1'b0, "o_done after reset");
        report_test("reset state");

        for (int f = 0; f < N_FRAMES; f++) begin
            if (!timed_out) begin
                check_bit(o_done, 1'b0, "o_done before last frame");
                run_frame($random(seed) & 3);
            end
        end
        check_bit(ack_count == N_FRAMES, 1'b1, "one ack per request");
        report_test("random blocks");

        check_bit(n_writes == N_BLOCKS - WIN_SIZE + 1, 1'b1, "result write count");
        check_bit(o_done, 1'b1, "o_done after all frames");
        addr_mark = o_sram_addr;
        @(posedge i_clk);
        i_req <= 1'b1;
        repeat (20) begin
            @(negedge i_clk);
            check_bit(o_ack, 1'b0, "ack while done");
            check_addr(o_sram_addr, addr_mark, "address while done");
        end
        @(posedge i_clk);
        i_req <= 1'b0;
        report_test("done and write count");

        fill_burst(BURST_BLK);
        compute_reference();
        apply_reset();
        for (int f = 0; f < N_FRAMES; f++) begin
            if (!timed_out)
                run_frame(0);
        end
        for (int j = WIN_SIZE / 2 - 1; j <= N_BLOCKS - 1 - WIN_SIZE / 2; j++)
            check_bit(res_bit[j], j == BURST_BLK, "burst beat bit");
        report_test("planted burst");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verification
design/onset_pkg.sv
design/bin_magnitude.sv
design/spectrum_accumulator.sv
design/flux_unit.sv
design/beat_window.sv
design/onset_ctrl.sv
design/onset_detector.sv
verification/tb_onset_detector.sv
